// File: hw/ciaBridgePkg.sv
// CIA bridge shared types
// CPU request, CIA decode result and CIA pin bundle,
// plus the CIA address map and chip-enable offsets
`default_nettype none

package ciaBridgePkg;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    // Upper address byte of the CIA window ($BFxxxx)
    localparam logic [7:0] CIA_PAGE = 8'hBF;
    // CIA-A answers on odd bytes, CIA-B on even bytes
    localparam logic CIA_A_ODD = 1'b1;

    ////////////////////////////////////////
    // Chip-enable offsets into PHI2-high
    ////////////////////////////////////////

    // Reads open early so data settles before PHI2 falls
    localparam int READ_EN_OFFSET = 3;
    // Writes open later, data sheet setup on R/W and data
    localparam int WRITE_EN_OFFSET = 6;

    // CPU side request, held stable while nTIP is low
    typedef struct packed {
        logic [23:0] addr;
        logic        rnw;
        // Big-endian, byte offset 0 in bits 31..24
        logic [31:0] writeData;
    } cpuReq_t;

    // Combinational decode of the request address
    typedef struct packed {
        logic       ciaSpace;
        logic       hitA;
        logic       hitB;
        logic [3:0] regNum;
    } ciaSel_t;

    // Everything driven onto the CIA side
    typedef struct packed {
        logic       nCsA;
        logic       nCsB;
        logic [3:0] rs;
        logic       rnw;
        logic [7:0] dataOut;
        logic       dataOe;
    } ciaPins_t;

endpackage

`default_nettype wire

// File: hw/ciaCycleSequencer.sv
// CIA cycle sequencer
// Divides CLK40 into the PHI2 CIA clock, opens the chip-enable
// window at the data-sheet offsets and ends each access with a
// single-clock TA pulse and a read capture strobe
`timescale 1ns/1ps
`default_nettype none

module ciaCycleSequencer #(
    parameter int PHI2_HALF = 10
) (
    input  wire  CLK40,
    input  wire  nRESET,
    input  wire  ciaSpace,
    input  wire  rnw,
    input  wire  nTIP,
    output logic phi2,
    output logic ciaEnable,
    output logic capture,
    output logic ciaTa
);

    import ciaBridgePkg::*;

    // Full PHI2 period in CLK40 cycles
    localparam int PERIOD = 2 * PHI2_HALF;
    localparam int CNT_W  = $clog2(PERIOD);

    // Counts at which things happen
    localparam logic [CNT_W-1:0] LAST_CNT     = CNT_W'(PERIOD - 1);
    localparam logic [CNT_W-1:0] CLEAR_CNT    = CNT_W'(1);
    localparam logic [CNT_W-1:0] READ_EN_CNT  = CNT_W'(PHI2_HALF + READ_EN_OFFSET);
    localparam logic [CNT_W-1:0] WRITE_EN_CNT = CNT_W'(PHI2_HALF + WRITE_EN_OFFSET);

    logic [CNT_W-1:0] phaseCnt;

    ////////////////////////////////////////
    // PHI2 clock
    ////////////////////////////////////////

    // Free running, wraps at the end of the PHI2 period
    always_ff @(negedge CLK40) begin
        if (!nRESET) begin
            phaseCnt <= '0;
        end else if (phaseCnt == LAST_CNT) begin
            phaseCnt <= '0;
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
        end
    end

    // Low for the first half, high for the second
    assign phi2 = (phaseCnt >= CNT_W'(PHI2_HALF));

    ////////////////////////////////////////
    // Chip enable and termination
    ////////////////////////////////////////

    always_ff @(negedge CLK40) begin
        if (!nRESET) begin
            ciaEnable <= 1'b0;
            ciaTa     <= 1'b0;
            capture   <= 1'b0;
        end else begin
            // TA and capture last exactly one clock
            if (phaseCnt == '0) begin
                ciaTa   <= 1'b0;
                capture <= 1'b0;
            end
            // Window closes just after PHI2 falls
            if (phaseCnt == CLEAR_CNT) begin
                ciaEnable <= 1'b0;
            end
            // Read window
            if (phaseCnt == READ_EN_CNT) begin
                ciaEnable <= rnw && ciaSpace && !nTIP;
            end
            // Write window, also keeps a late-started read open
            if (phaseCnt == WRITE_EN_CNT) begin
                ciaEnable <= ciaSpace && !nTIP;
            end
            // Terminate on the last count of PHI2-high
            if (phaseCnt == LAST_CNT) begin
                ciaTa   <= ciaEnable;
                capture <= ciaEnable && rnw;
            end
        end
    end

    // One TA per access, never stretched
    assert property (@(negedge CLK40) disable iff (!nRESET)
        ciaTa |=> !ciaTa);

    // Window only opens for a cycle the CPU has started
    assert property (@(negedge CLK40) disable iff (!nRESET)
        $rose(ciaEnable) |-> !$past(nTIP));

endmodule

`default_nettype wire

// File: hw/ciaAddressDecode.sv
// CIA address decode
// Finds the CIA window, the chip hits and the register number,
// and registers the CIA selects inside the chip-enable window
`timescale 1ns/1ps
`default_nettype none

module ciaAddressDecode (
    input  wire                   CLK40,
    input  wire                   nRESET,
    input  ciaBridgePkg::cpuReq_t req,
    input  wire                   ciaEnable,
    output ciaBridgePkg::ciaSel_t sel,
    output logic                  nCsA,
    output logic                  nCsB,
    output logic [3:0]            rs,
    output logic                  rnwPin
);

    import ciaBridgePkg::*;

    logic laneA;
    logic selA;
    logic selB;

    ////////////////////////////////////////
    // Window and chip decode
    ////////////////////////////////////////

    always_comb begin
        sel.ciaSpace = (req.addr[23:16] == CIA_PAGE);
        // Chip hits are active low address lines
        sel.hitA     = !req.addr[12];
        sel.hitB     = !req.addr[13];
        sel.regNum   = req.addr[11:8];
    end

    // Byte lane that belongs to CIA-A
    assign laneA = (req.addr[0] == CIA_A_ODD);

    // Each chip only on its own byte lane
    assign selA = ciaEnable && sel.ciaSpace && sel.hitA && laneA;
    assign selB = ciaEnable && sel.ciaSpace && sel.hitB && !laneA;

    ////////////////////////////////////////
    // Registered CIA selects
    ////////////////////////////////////////

    // Pins only move on a CLK40 edge, no decode glitches
    always_ff @(negedge CLK40) begin
        if (!nRESET) begin
            nCsA   <= 1'b1;
            nCsB   <= 1'b1;
            rs     <= '0;
            rnwPin <= 1'b1;
        end else begin
            nCsA   <= !selA;
            nCsB   <= !selB;
            rs     <= sel.regNum;
            // Parked as read outside the window
            rnwPin <= ciaEnable ? req.rnw : 1'b1;
        end
    end

    // A select is only ever loaded from a CIA-space address
    assert property (@(negedge CLK40) disable iff (!nRESET)
        (!nCsA || !nCsB) |-> $past(sel.ciaSpace));

endmodule

`default_nettype wire

// File: hw/ciaDataLanes.sv
// CIA data lanes
// Steers the addressed write byte onto the 8-bit CIA bus and
// returns the read byte replicated on all four CPU lanes
`timescale 1ns/1ps
`default_nettype none

module ciaDataLanes (
    input  wire                   CLK40,
    input  wire                   nRESET,
    input  ciaBridgePkg::cpuReq_t req,
    input  ciaBridgePkg::ciaSel_t sel,
    input  wire                   ciaEnable,
    input  wire                   capture,
    input  wire  [7:0]            ciaDataA,
    input  wire  [7:0]            ciaDataB,
    output logic [7:0]            dataOut,
    output logic                  dataOe,
    output logic [31:0]           readData
);

    import ciaBridgePkg::*;

    logic [7:0] writeByte;
    logic [7:0] liveByte;
    logic [7:0] busByte;
    logic [7:0] heldByte;

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    // Big-endian lanes, offset 0 is the top byte
    always_comb begin
        case (req.addr[1:0])
            2'd0: writeByte = req.writeData[31:24];
            2'd1: writeByte = req.writeData[23:16];
            2'd2: writeByte = req.writeData[15:8];
            default: writeByte = req.writeData[7:0];
        endcase
    end

    // Registered so data and OE line up with the selects
    always_ff @(negedge CLK40) begin
        dataOut <= writeByte;
    end

    always_ff @(negedge CLK40) begin
        if (!nRESET) begin
            dataOe <= 1'b0;
        end else begin
            // Drive only for a decoded write inside the window
            dataOe <= ciaEnable && sel.ciaSpace && !req.rnw
                      && (sel.hitA || sel.hitB);
        end
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    // Odd bytes come from CIA-A, even bytes from CIA-B
    assign liveByte = (req.addr[0] == CIA_A_ODD) ? ciaDataA : ciaDataB;

    // Bus sampled every clock
    // The sample taken at the end of PHI2-high is the one kept
    always_ff @(negedge CLK40) begin
        busByte <= liveByte;
    end

    // Frozen at the capture edge, held until the next read
    always_ff @(negedge CLK40) begin
        if (capture) begin
            heldByte <= busByte;
        end
    end

    // Bypass during the TA clock so data is valid with TA
    assign readData = capture ? {4{busByte}} : {4{heldByte}};

endmodule

`default_nettype wire

// File: hw/ciaBridge.sv
// CIA bridge top level
// Connects the cycle sequencer, address decode and data lanes
// between the 68040 local bus and the two 8520 CIAs
`timescale 1ns/1ps
`default_nettype none

module ciaBridge #(
    // PHI2 half period in CLK40 cycles, 10 gives 2 MHz
    parameter int PHI2_HALF = 10
) (
    input  wire                    CLK40,
    input  wire                    nRESET,
    input  ciaBridgePkg::cpuReq_t  req,
    input  wire                    nTIP,
    input  wire  [7:0]             ciaDataA,
    input  wire  [7:0]             ciaDataB,
    output logic                   phi2,
    output ciaBridgePkg::ciaPins_t pins,
    output logic [31:0]            readData,
    output logic                   ciaTa
);

    import ciaBridgePkg::*;

    ciaSel_t    sel;
    logic       ciaEnable;
    logic       capture;
    logic       nCsA;
    logic       nCsB;
    logic [3:0] rs;
    logic       rnwPin;
    logic [7:0] dataOut;
    logic       dataOe;

    ////////////////////////////////////////
    // Timing
    ////////////////////////////////////////

    ciaCycleSequencer #(
        .PHI2_HALF (PHI2_HALF)
    ) ciaCycleSequencer_inst (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .ciaSpace  (sel.ciaSpace),
        .rnw       (req.rnw),
        .nTIP      (nTIP),
        .phi2      (phi2),
        .ciaEnable (ciaEnable),
        .capture   (capture),
        .ciaTa     (ciaTa)
    );

    ////////////////////////////////////////
    // Decode and data
    ////////////////////////////////////////

    ciaAddressDecode ciaAddressDecode_inst (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .req       (req),
        .ciaEnable (ciaEnable),
        .sel       (sel),
        .nCsA      (nCsA),
        .nCsB      (nCsB),
        .rs        (rs),
        .rnwPin    (rnwPin)
    );

    ciaDataLanes ciaDataLanes_inst (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .req       (req),
        .sel       (sel),
        .ciaEnable (ciaEnable),
        .capture   (capture),
        .ciaDataA  (ciaDataA),
        .ciaDataB  (ciaDataB),
        .dataOut   (dataOut),
        .dataOe    (dataOe),
        .readData  (readData)
    );

    // CIA pin bundle
    assign pins = '{nCsA: nCsA, nCsB: nCsB, rs: rs, rnw: rnwPin,
                    dataOut: dataOut, dataOe: dataOe};

endmodule

`default_nettype wire

// File: verif/ciaBridgeTb.sv
// CIA bridge testbench
// Register model of both CIAs, reference for write lanes and read
// data, random accesses and a checker on the CIA pins and TA
`timescale 1ns/1ps
`default_nettype none

module ciaBridgeTb;

    import ciaBridgePkg::*;

    localparam int PHI2_HALF = 10;
    localparam int NUM_PAIRS = 20;
    localparam int NUM_TX = 2 * NUM_PAIRS;
    // Worst case per access is latency plus the idle gap
    localparam int TX_CLOCKS = 60;
    localparam int OUTSIDE_CLOCKS = 60;
    localparam int TIMEOUT_CYCLES = NUM_TX * TX_CLOCKS + OUTSIDE_CLOCKS + 300;

    logic CLK40 = 1'b0;
    logic nRESET;
    logic nTIP;
    cpuReq_t req;
    logic [7:0] ciaDataA;
    logic [7:0] ciaDataB;
    logic phi2;
    ciaPins_t pins;
    logic [31:0] readData;
    logic ciaTa;

    // CIA register model and the expected contents
    logic [7:0] regA [16];
    logic [7:0] regB [16];
    logic [7:0] shadowA [16];
    logic [7:0] shadowB [16];
    logic modelPhi2;

    // Current access as seen by the checker
    logic curActive;
    logic curOutside;
    logic curIsRead;
    logic curChipA;
    logic [3:0] curReg;
    logic [7:0] curWriteByte;
    logic [31:0] expRead;
    logic writePending;
    logic prevPhi2;
    logic prevCsA;
    logic prevCsB;
    int highIdx;
    int taCount;
    int cycleCnt;
    logic [31:0] lcgState;

    always #5 CLK40 = ~CLK40;

    ciaBridge #(
        .PHI2_HALF (PHI2_HALF)
    ) ciaBridge_inst (
        .CLK40    (CLK40),
        .nRESET   (nRESET),
        .req      (req),
        .nTIP     (nTIP),
        .ciaDataA (ciaDataA),
        .ciaDataB (ciaDataB),
        .phi2     (phi2),
        .pins     (pins),
        .readData (readData),
        .ciaTa    (ciaTa)
    );

    ////////////////////////////////////////
    // Helpers and reference
    ////////////////////////////////////////

    task stopWithError(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task reportMismatch(input string name, input logic [31:0] got, input logic [31:0] expVal);
        stopWithError($sformatf("ERR %0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, expVal));
    endtask

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'h0, lcgState[30:15]};
    endfunction

    // Power-up contents differ per chip and register
    function logic [7:0] fillByte(input logic chipA, input int idx);
        return 8'(idx * 29) ^ (chipA ? 8'h5A : 8'hC3);
    endfunction

    // Big-endian lane pick with offset 0 in bits 31..24
    function logic [7:0] pickWriteByte(input logic [1:0] lane, input logic [31:0] data);
        case (lane)
            2'd0: return data[31:24];
            2'd1: return data[23:16];
            2'd2: return data[15:8];
            default: return data[7:0];
        endcase
    endfunction

    // Addressed register on all four lanes
    function logic [31:0] expectedRead(input logic chipA, input logic [3:0] regNum);
        return {4{chipA ? shadowA[regNum] : shadowB[regNum]}};
    endfunction

    ////////////////////////////////////////
    // CIA model
    ////////////////////////////////////////

    // Deselected chip floats high
    assign ciaDataA = pins.nCsA ? 8'hFF : regA[pins.rs];
    assign ciaDataB = pins.nCsB ? 8'hFF : regB[pins.rs];

    // Write lands where PHI2 falls
    always @(posedge CLK40) begin
        if (modelPhi2 && !phi2 && !pins.rnw) begin
            if (!pins.nCsA) regA[pins.rs] <= pins.dataOut;
            if (!pins.nCsB) regB[pins.rs] <= pins.dataOut;
        end
        modelPhi2 <= phi2;
    end

    ////////////////////////////////////////
    // Checker
    ////////////////////////////////////////

    always @(posedge CLK40) begin
        if (nRESET) begin
            if (ciaTa) taCount = taCount + 1;
            // Clocks since PHI2 rose
            if (phi2 && prevPhi2) highIdx = highIdx + 1;
            else highIdx = 0;
            if ((prevCsA && !pins.nCsA) || (prevCsB && !pins.nCsB)) begin
                assert (phi2) else stopWithError("A chip select fell while phi2 was low");
                assert (highIdx >= (curIsRead ? READ_EN_OFFSET : WRITE_EN_OFFSET))
                    else stopWithError("A chip select fell before the enable offset");
            end
            // Only the addressed chip is selected
            if (curActive) begin
                if (curChipA) begin
                    assert (pins.nCsB) else reportMismatch("pins.nCsB", pins.nCsB, 1);
                end else begin
                    assert (pins.nCsA) else reportMismatch("pins.nCsA", pins.nCsA, 1);
                end
            end
            if (!pins.nCsA || !pins.nCsB) begin
                assert (pins.rnw == curIsRead)
                    else reportMismatch("pins.rnw", pins.rnw, curIsRead);
                assert (pins.dataOe == !curIsRead)
                    else reportMismatch("pins.dataOe", pins.dataOe, !curIsRead);
                if (!curIsRead) begin
                    assert (pins.dataOut == curWriteByte)
                        else reportMismatch("pins.dataOut", pins.dataOut, curWriteByte);
                end
            end
            if (curOutside) begin
                assert (!ciaTa)
                    else stopWithError("ciaTa came for an address outside the window");
                assert (pins.nCsA && pins.nCsB)
                    else stopWithError("A chip was selected outside the CIA window");
            end
            if (ciaTa && curIsRead && curActive) begin
                assert (readData == expRead) else reportMismatch("readData", readData, expRead);
            end
            // Model was written on the TA clock
            if (writePending) begin
                assert (regA[curReg] == shadowA[curReg])
                    else reportMismatch("regA", regA[curReg], shadowA[curReg]);
                assert (regB[curReg] == shadowB[curReg])
                    else reportMismatch("regB", regB[curReg], shadowB[curReg]);
            end
            writePending = ciaTa && !curIsRead && curActive;
        end
        prevPhi2 = phi2;
        prevCsA = pins.nCsA;
        prevCsB = pins.nCsB;
    end

    always @(posedge CLK40) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > TIMEOUT_CYCLES) begin
            stopWithError("Timeout, the run went past its cycle limit");
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task checkResetState();
        int gap;
        logic lastPhi;
        @(posedge CLK40);
        assert (!ciaTa) else reportMismatch("ciaTa", ciaTa, 0);
        assert (pins.nCsA) else reportMismatch("pins.nCsA", pins.nCsA, 1);
        assert (pins.nCsB) else reportMismatch("pins.nCsB", pins.nCsB, 1);
        assert (!pins.dataOe) else reportMismatch("pins.dataOe", pins.dataOe, 0);
        lastPhi = phi2;
        while (phi2 == lastPhi) @(posedge CLK40);
        // Two full halves after the first edge
        repeat (2) begin
            lastPhi = phi2;
            gap = 0;
            while (phi2 == lastPhi) begin
                @(posedge CLK40);
                gap = gap + 1;
            end
            assert (gap == PHI2_HALF) else reportMismatch("phi2 half period", gap, PHI2_HALF);
        end
    endtask

    task runAccess(input logic isRead, input logic chipA, input logic [3:0] regNum,
                   input logic laneHigh, input logic [31:0] data);
        cpuReq_t r;
        logic [3:0] chipNibble;
        int startTa;
        int gap;
        // $BFExx1 reaches CIA-A and $BFDxx0 reaches CIA-B
        // $BFCxxx hits both chips so only address bit 0 steers
        if (1'(nextRand())) begin
            chipNibble = 4'hC;
        end else begin
            chipNibble = chipA ? 4'hE : 4'hD;
        end
        r.addr = {CIA_PAGE, chipNibble, regNum, 6'b0, laneHigh, chipA};
        r.rnw = isRead;
        r.writeData = data;
        if (!isRead) begin
            curWriteByte = pickWriteByte(r.addr[1:0], data);
            if (chipA) shadowA[regNum] = curWriteByte;
            else shadowB[regNum] = curWriteByte;
        end
        @(posedge CLK40);
        expRead = expectedRead(chipA, regNum);
        curIsRead = isRead;
        curChipA = chipA;
        curReg = regNum;
        curActive = 1'b1;
        startTa = taCount;
        req = r;
        nTIP = 1'b0;
        @(posedge CLK40);
        while (!ciaTa) @(posedge CLK40);
        nTIP = 1'b1;
        // Idle long enough to catch a second TA
        gap = 2 * PHI2_HALF + int'(nextRand() % 8);
        repeat (gap) @(posedge CLK40);
        assert (taCount == startTa + 1)
            else reportMismatch("ciaTa pulse count", taCount - startTa, 1);
        curActive = 1'b0;
    endtask

    task runOutsideAccess();
        @(posedge CLK40);
        curOutside = 1'b1;
        req.addr = {8'hBE, 4'hE, 4'h3, 6'b0, 1'b0, 1'b1};
        req.rnw = 1'(nextRand());
        nTIP = 1'b0;
        repeat (OUTSIDE_CLOCKS) @(posedge CLK40);
        nTIP = 1'b1;
        repeat (4) @(posedge CLK40);
        curOutside = 1'b0;
    endtask

    initial begin
        logic chipA;
        logic [3:0] regNum;
        logic [31:0] hi;
        logic [31:0] lo;
        nRESET = 1'b0;
        nTIP = 1'b1;
        req = '0;
        lcgState = 32'd5;
        modelPhi2 = 1'b0;
        curActive = 1'b0;
        curOutside = 1'b0;
        curIsRead = 1'b1;
        curChipA = 1'b0;
        curReg = '0;
        curWriteByte = '0;
        expRead = '0;
        writePending = 1'b0;
        prevPhi2 = 1'b0;
        prevCsA = 1'b1;
        prevCsB = 1'b1;
        highIdx = 0;
        taCount = 0;
        cycleCnt = 0;
        for (int i = 0; i < 16; i++) begin
            regA[i] = fillByte(1'b1, i);
            regB[i] = fillByte(1'b0, i);
            shadowA[i] = fillByte(1'b1, i);
            shadowB[i] = fillByte(1'b0, i);
        end
        // Three active edges in reset
        repeat (3) @(negedge CLK40);
        @(posedge CLK40);
        nRESET = 1'b1;
        checkResetState();
        for (int i = 0; i < NUM_PAIRS; i++) begin
            chipA = 1'(nextRand());
            regNum = 4'(nextRand());
            hi = nextRand();
            lo = nextRand();
            runAccess(1'b0, chipA, regNum, 1'(nextRand()), {hi[15:0], lo[15:0]});
            // Even passes read the register just written
            if (i % 2 == 0) begin
                runAccess(1'b1, chipA, regNum, 1'(nextRand()), '0);
            end else begin
                chipA = 1'(nextRand());
                runAccess(1'b1, chipA, 4'(nextRand()), 1'(nextRand()), '0);
            end
        end
        runOutsideAccess();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/ciaBridgePkg.sv
hw/ciaCycleSequencer.sv
hw/ciaAddressDecode.sv
hw/ciaDataLanes.sv
hw/ciaBridge.sv
verif/ciaBridgeTb.sv

// File: Bender.yml
# CIA peripheral bridge for the 68040 local bus
package:
  name: ciaBridge

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hw/ciaBridgePkg.sv
      - hw/ciaCycleSequencer.sv
      - hw/ciaAddressDecode.sv
      - hw/ciaDataLanes.sv
      - hw/ciaBridge.sv

  # Testbench, top module ciaBridgeTb
  - target: test
    files:
      - verif/ciaBridgeTb.sv
